// ==== project.f ====
hdl/eeprom_pkg.sv
hdl/eeprom_chan_if.sv
hdl/eeprom_dispatch.sv
hdl/eeprom_wr.sv
hdl/eeprom_collect.sv
hdl/eeprom_multi_top.sv
bench/eeprom_model.sv
bench/tb_eeprom_multi.sv

// ==== Bender.yml ====
package:
  name: eeprom_multi

sources:
  - hdl/eeprom_pkg.sv
  - hdl/eeprom_chan_if.sv
  - hdl/eeprom_dispatch.sv
  - hdl/eeprom_wr.sv
  - hdl/eeprom_collect.sv
  - hdl/eeprom_multi_top.sv
  - target: test
    files:
      - bench/eeprom_model.sv
      - bench/tb_eeprom_multi.sv

// ==== bench/tb_eeprom_multi.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_eeprom_multi;

    localparam int NCHAN = 4;
    localparam int WAIT_LIMIT = 4000;
    localparam int QUIET_CYCLES = 1000;

    logic             CLK;
    logic             RESET;
    logic             WR;
    logic             RD;
    logic [12:0]      ADDR;
    logic [7:0]       WDATA;
    logic             BUSY;
    logic             ACK;
    logic [1:0]       ACK_CHAN;
    logic [7:0]       RDATA;
    logic             NACK;
    wire  [NCHAN-1:0] scl;
    wire  [NCHAN-1:0] sda;

    logic [7:0]  ref_mem [NCHAN][2048];
    logic [11:0] expect_q [$];          // read, nack, channel, data
    logic [10:0] addr_list [3];
    int          errors;
    int          acks;

    eeprom_multi_top #(
        .NCHAN       (NCHAN),
        .SCL_QUARTER (2)
    ) dut (
        .CLK      (CLK),
        .RESET    (RESET),
        .WR       (WR),
        .RD       (RD),
        .ADDR     (ADDR),
        .WDATA    (WDATA),
        .BUSY     (BUSY),
        .ACK      (ACK),
        .ACK_CHAN (ACK_CHAN),
        .RDATA    (RDATA),
        .NACK     (NACK),
        .SCL      (scl),
        .SDA      (sda)
    );

    for (genvar i = 0; i < NCHAN; i++)
    begin : g_pull
        pullup (scl[i]);
        pullup (sda[i]);
    end

    // channel 3 left without a device
    for (genvar i = 0; i < 3; i++)
    begin : g_mem
        eeprom_model u_model (
            .SCL (scl[i]),
            .SDA (sda[i])
        );
    end

    initial
    begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    assert property (@(posedge CLK) disable iff (RESET) NACK |-> ACK)
    else
    begin
        errors++;
        $display("FAIL t=%0t ACK expected 1 got %b while NACK high", $time, ACK);
    end

    assert property (@(posedge CLK) disable iff (RESET) ACK |-> !$isunknown({ACK_CHAN, NACK}))
    else
    begin
        errors++;
        $display("FAIL t=%0t ACK_CHAN expected known got %b", $time, ACK_CHAN);
    end

    task automatic check_idle();
        assert (BUSY === 1'b0 && ACK === 1'b0 && NACK === 1'b0)
        else
        begin
            errors++;
            $display("FAIL t=%0t BUSY,ACK,NACK expected 000 got %b%b%b", $time, BUSY, ACK, NACK);
        end
        assert (scl === 4'hf)
        else
        begin
            errors++;
            $display("FAIL t=%0t SCL expected f got %h", $time, scl);
        end
        assert (sda === 4'hf)
        else
        begin
            errors++;
            $display("FAIL t=%0t SDA expected f got %h", $time, sda);
        end
    endtask

    // oldest outstanding request of the acknowledged channel
    task automatic match_ack();
        int hit;
        hit = -1;
        acks++;
        for (int k = 0; k < expect_q.size(); k++)
        begin
            if (hit < 0 && expect_q[k][9:8] == ACK_CHAN)
                hit = k;
        end
        assert (hit >= 0)
        else
        begin
            errors++;
            $display("ACK on channel %0d at %0t without an outstanding request", ACK_CHAN, $time);
        end
        if (hit >= 0)
        begin
            assert (NACK === expect_q[hit][10])
            else
            begin
                errors++;
                $display("FAIL t=%0t NACK expected %b got %b", $time, expect_q[hit][10], NACK);
            end
            assert (!expect_q[hit][11] || RDATA === expect_q[hit][7:0])
            else
            begin
                errors++;
                $display("FAIL t=%0t RDATA expected %h got %h", $time, expect_q[hit][7:0], RDATA);
            end
            expect_q.delete(hit);
        end
    endtask

    always @(posedge CLK)
    begin
        if (!RESET && ACK === 1'b1)
            match_ack();
    end

    task automatic issue(input logic rd, input logic [1:0] chan, input logic [10:0] a,
                         input logic [7:0] d);
        int t;
        t = 0;
        while (BUSY !== 1'b0 && t < WAIT_LIMIT)
        begin
            @(posedge CLK);
            #1;
            t++;
        end
        if (BUSY !== 1'b0)
        begin
            errors++;
            $display("timeout: BUSY stayed high, request to channel %0d not issued", chan);
        end
        else
        begin
            if (rd)
                expect_q.push_back({1'b1, chan == 2'd3, chan,
                                    (chan == 2'd3) ? 8'hff : ref_mem[chan][a]});  // floating bus
            else
            begin
                expect_q.push_back({1'b0, chan == 2'd3, chan, 8'h00});
                ref_mem[chan][a] = d;
            end
            ADDR  = {chan, a};
            WDATA = d;
            WR    = !rd;
            RD    = rd;
            @(posedge CLK);
            #1;
            WR = 1'b0;
            RD = 1'b0;
        end
    endtask

    task automatic stray_strobe();
        assert (BUSY === 1'b1)
        else
        begin
            errors++;
            $display("FAIL t=%0t BUSY expected 1 got %b", $time, BUSY);
        end
        ADDR = {2'd3, 11'h155};
        RD   = 1'b1;
        @(posedge CLK);
        #1;
        RD = 1'b0;
    endtask

    task automatic drain();
        int t;
        t = 0;
        while ((expect_q.size() != 0 || BUSY !== 1'b0) && t < WAIT_LIMIT)
        begin
            @(posedge CLK);
            #1;
            t++;
        end
        if (expect_q.size() != 0)
        begin
            errors++;
            $display("timeout: %0d requests never acknowledged", expect_q.size());
        end
        repeat (QUIET_CYCLES) @(posedge CLK);   // window for an extra ACK
        #1;
    endtask

    initial
    begin
        int total;
        errors = 0;
        acks = 0;
        RESET = 1'b1;
        WR = 1'b0;
        RD = 1'b0;
        ADDR = '0;
        WDATA = '0;
        void'($urandom(82164));
        repeat (5) @(posedge CLK);
        #1;
        RESET = 1'b0;
        check_idle();

        issue(1'b0, 2'd0, 11'h2a5, 8'hc3);
        issue(1'b1, 2'd0, 11'h2a5, 8'h00);

        // same word address, different bytes
        for (int c = 0; c < 3; c++)
            issue(1'b0, 2'(c), 11'h07f, 8'(8'h11 * (c + 1)));
        for (int c = 0; c < 3; c++)
            issue(1'b1, 2'(c), 11'h07f, 8'h00);

        repeat (4)
        begin
            for (int c = 0; c < 3; c++)
            begin
                addr_list[c] = 11'($urandom);
                issue(1'b0, 2'(c), addr_list[c], 8'($urandom));
            end
            for (int c = 0; c < 3; c++)
                issue(1'b1, 2'(c), addr_list[c], 8'h00);
        end

        issue(1'b0, 2'd3, 11'h3c0, 8'h77);
        issue(1'b1, 2'd3, 11'h3c0, 8'h00);

        // second request holds BUSY high for the whole write
        issue(1'b0, 2'd1, 11'h400, 8'h9e);
        issue(1'b1, 2'd1, 11'h400, 8'h00);
        stray_strobe();
        drain();

        total = errors + g_mem[0].u_model.errors + g_mem[1].u_model.errors +
                g_mem[2].u_model.errors;
        $display("errors: %0d, ACKs received: %0d", total, acks);
        if (total == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/eeprom_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module eeprom_model (
    inout wire SCL,
    inout wire SDA
);

    localparam int M_IDLE  = 0;
    localparam int M_CTRL  = 1;
    localparam int M_ADDR  = 2;
    localparam int M_WDATA = 3;
    localparam int M_RDATA = 4;

    logic [7:0]  mem [2048];
    logic [7:0]  sh;
    logic [7:0]  tx;
    logic [10:0] ptr;
    logic        sda_low;
    int          mode;
    int          nbit;
    int          errors;

    assign SDA = sda_low ? 1'b0 : 1'bz;

    initial
    begin
        sda_low = 1'b0;
        mode = M_IDLE;
        nbit = 0;
        errors = 0;
        ptr = '0;
        for (int a = 0; a < 2048; a++)
            mem[a] = 8'(a) ^ 8'(a >> 3);    // every address bit shows up
    end

    // start and stop, only legal in the first bit slot of a byte
    always @(SDA)
    begin
        if (SCL === 1'b1 && !$isunknown(SDA))
        begin
            assert (nbit <= 1)
            else
            begin
                errors++;
                $display("model: SDA changed with SCL high inside a byte at %0t", $time);
            end
            sda_low = 1'b0;
            nbit = 0;
            mode = (SDA == 1'b0) ? M_CTRL : M_IDLE;
        end
    end

    always @(posedge SCL)
    begin
        if (mode != M_IDLE)
        begin
            if (mode != M_RDATA && nbit < 8)
                sh = {sh[6:0], SDA === 1'b1};
            nbit++;
        end
    end

    always @(negedge SCL)
    begin
        if (mode == M_RDATA)
        begin
            if (nbit == 8)
                sda_low = 1'b0;             // master ack slot
            else if (nbit == 9)
            begin
                mode = M_IDLE;              // single byte read only
                nbit = 0;
            end
            else
                sda_low = !tx[7 - nbit];
        end
        else if (mode != M_IDLE && nbit == 8)
        begin
            sda_low = 1'b1;
            if (mode == M_CTRL && sh[7:4] != 4'b1010)
            begin
                sda_low = 1'b0;             // not for us
                mode = M_IDLE;
                nbit = 0;
            end
            else if (mode == M_CTRL)
                ptr[10:8] = sh[3:1];
            else if (mode == M_ADDR)
                ptr[7:0] = sh;
            else
            begin
                mem[ptr] = sh;
                ptr = ptr + 1'b1;
            end
        end
        else if (mode != M_IDLE && nbit == 9)
        begin
            sda_low = 1'b0;
            nbit = 0;
            if (mode == M_CTRL && sh[0])
            begin
                mode = M_RDATA;
                tx = mem[ptr];
                ptr = ptr + 1'b1;
                sda_low = !tx[7];
            end
            else if (mode == M_CTRL)
                mode = M_ADDR;
            else
                mode = M_WDATA;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/eeprom_multi_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module eeprom_multi_top #(
    parameter int NCHAN       = 4,
    parameter int SCL_QUARTER = 2
) (
    input  logic                                           CLK,
    input  logic                                           RESET,
    input  logic                                           WR,
    input  logic                                           RD,
    input  logic [$clog2(NCHAN)+eeprom_pkg::ADDR_W-1:0]    ADDR,   // channel in upper bits
    input  logic [eeprom_pkg::DATA_W-1:0]                  WDATA,
    output logic                                           BUSY,
    output logic                                           ACK,
    output logic [$clog2(NCHAN)-1:0]                       ACK_CHAN,
    output logic [eeprom_pkg::DATA_W-1:0]                  RDATA,
    output logic                                           NACK,
    inout  wire  [NCHAN-1:0]                               SCL,    // open drain
    inout  wire  [NCHAN-1:0]                               SDA
);

    eeprom_chan_if chan_bus [NCHAN] ();

    eeprom_dispatch #(
        .NCHAN (NCHAN)
    ) u_dispatch (
        .CLK   (CLK),
        .RESET (RESET),
        .WR    (WR),
        .RD    (RD),
        .ADDR  (ADDR),
        .WDATA (WDATA),
        .BUSY  (BUSY),
        .ch    (chan_bus)
    );

    for (genvar g = 0; g < NCHAN; g++)
    begin : g_chan
        eeprom_wr #(
            .SCL_QUARTER (SCL_QUARTER)
        ) u_wr (
            .CLK   (CLK),
            .RESET (RESET),
            .bus   (chan_bus[g]),
            .SCL   (SCL[g]),
            .SDA   (SDA[g])
        );
    end

    eeprom_collect #(
        .NCHAN (NCHAN)
    ) u_collect (
        .CLK      (CLK),
        .RESET    (RESET),
        .ch       (chan_bus),
        .ACK      (ACK),
        .ACK_CHAN (ACK_CHAN),
        .RDATA    (RDATA),
        .NACK     (NACK)
    );

endmodule

`default_nettype wire

// ==== hdl/eeprom_collect.sv ====
`timescale 1ns/1ps
`default_nettype none

module eeprom_collect #(
    parameter int NCHAN = 4
) (
    input  logic                            CLK,
    input  logic                            RESET,
    eeprom_chan_if.collect                  ch [NCHAN],
    output logic                            ACK,
    output logic [$clog2(NCHAN)-1:0]        ACK_CHAN,
    output logic [eeprom_pkg::DATA_W-1:0]   RDATA,
    output logic                            NACK
);

    localparam int CHAN_W = $clog2(NCHAN);

    logic [NCHAN-1:0]                done_v;
    logic [NCHAN-1:0]                nack_v;
    logic [NCHAN-1:0]                read_v;
    logic [eeprom_pkg::DATA_W-1:0]   rdata_v [NCHAN];
    logic [NCHAN-1:0]                pend;
    logic [NCHAN-1:0]                nack_q;
    logic [NCHAN-1:0]                read_q;
    logic [eeprom_pkg::DATA_W-1:0]   rdata_q [NCHAN];
    logic [CHAN_W-1:0]               sel;
    logic                            any;

    for (genvar i = 0; i < NCHAN; i++)
    begin : g_ch
        assign done_v[i]  = ch[i].done;
        assign nack_v[i]  = ch[i].nack;
        assign read_v[i]  = (ch[i].op == eeprom_pkg::OP_READ);
        assign rdata_v[i] = ch[i].rdata;

        assert property (@(posedge CLK) disable iff (RESET)
            done_v[i] |-> !pend[i])
            else $error("channel %0d completed again before its ACK", i);
    end

    // lowest pending channel wins
    always_comb
    begin
        sel = '0;
        any = 1'b0;
        for (int i = NCHAN - 1; i >= 0; i--)
        begin
            if (pend[i])
            begin
                sel = CHAN_W'(i);
                any = 1'b1;
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
            pend <= '0;
        else
            for (int i = 0; i < NCHAN; i++)
            begin
                if (done_v[i])
                    pend[i] <= 1'b1;
                else if (any && sel == CHAN_W'(i))
                    pend[i] <= 1'b0;
            end
    end

    always_ff @(posedge CLK)
    begin
        for (int i = 0; i < NCHAN; i++)
        begin
            if (done_v[i])
            begin
                rdata_q[i] <= rdata_v[i];
                nack_q[i]  <= nack_v[i];
                read_q[i]  <= read_v[i];
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            ACK  <= 1'b0;
            NACK <= 1'b0;
        end
        else
        begin
            ACK  <= any;
            NACK <= any && nack_q[sel];
        end
    end

    always_ff @(posedge CLK)
    begin
        if (any)
        begin
            ACK_CHAN <= sel;
            RDATA    <= read_q[sel] ? rdata_q[sel] : '0;   // writes report zero
        end
    end

endmodule

`default_nettype wire

// ==== hdl/eeprom_wr.sv ====
`timescale 1ns/1ps
`default_nettype none

module eeprom_wr #(
    parameter int SCL_QUARTER = 2
) (
    input logic          CLK,
    input logic          RESET,
    eeprom_chan_if.chan  bus,
    inout wire           SCL,
    inout wire           SDA
);

    localparam int QW = (SCL_QUARTER > 1) ? $clog2(SCL_QUARTER) : 1;
    localparam logic [3:0] ACK_SLOT = 4'(eeprom_pkg::DATA_W);

    eeprom_pkg::chan_state_e         state;
    eeprom_pkg::bit_phase_e          phase;
    logic [QW-1:0]                   qcnt;
    logic                            tick;
    logic [3:0]                      bitcnt;
    logic                            ack_bit;
    logic                            byte_state;
    logic [eeprom_pkg::DATA_W-1:0]   sh;
    logic                            load;
    logic [eeprom_pkg::DATA_W-1:0]   load_byte;
    logic                            scl_oe;     // high pulls SCL low
    logic                            sda_oe;     // high pulls SDA low
    logic                            sda_in;
    logic                            busy_q;
    logic                            done_q;
    logic                            nack_q;
    eeprom_pkg::op_e                 op_q;
    logic [eeprom_pkg::ADDR_W-1:0]   addr_q;
    logic [eeprom_pkg::DATA_W-1:0]   wdata_q;

    assign SCL = scl_oe ? 1'b0 : 1'bz;
    assign SDA = sda_oe ? 1'b0 : 1'bz;
    assign sda_in = SDA;

    assign tick = (qcnt == QW'(SCL_QUARTER - 1));
    assign ack_bit = (bitcnt == ACK_SLOT);
    assign byte_state = state inside {eeprom_pkg::CTRL_W, eeprom_pkg::ADDR, eeprom_pkg::DATA_WR,
                                      eeprom_pkg::CTRL_R, eeprom_pkg::DATA_RD};

    assign bus.busy  = busy_q;
    assign bus.done  = done_q;
    assign bus.nack  = nack_q;
    assign bus.rdata = sh;          // read byte stays put through STOP and DONE

    always_ff @(posedge CLK)
    begin
        if (RESET)
            qcnt <= '0;
        else if (state == eeprom_pkg::IDLE || tick)
            qcnt <= '0;
        else
            qcnt <= qcnt + 1'b1;
    end

    // next byte to send, loaded at the end of a slot
    always_comb
    begin
        load = 1'b0;
        load_byte = wdata_q;
        if (tick && phase == eeprom_pkg::PH_LOW1)
        begin
            case (state)
                eeprom_pkg::START:
                begin
                    load = 1'b1;
                    load_byte = {eeprom_pkg::DEV_TYPE, addr_q[eeprom_pkg::ADDR_W-1:8], 1'b0};
                end
                eeprom_pkg::RESTART:
                begin
                    load = 1'b1;
                    load_byte = {eeprom_pkg::DEV_TYPE, addr_q[eeprom_pkg::ADDR_W-1:8], 1'b1};
                end
                eeprom_pkg::CTRL_W:
                begin
                    load = ack_bit;
                    load_byte = addr_q[7:0];
                end
                eeprom_pkg::ADDR:
                    load = ack_bit && (op_q == eeprom_pkg::OP_WRITE);
                default:
                    load = 1'b0;
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (state == eeprom_pkg::IDLE && bus.start)
        begin
            op_q    <= bus.op;
            addr_q  <= bus.addr;
            wdata_q <= bus.wdata;
        end
        if (tick && phase == eeprom_pkg::PH_HIGH0 && byte_state && !ack_bit)
            sh <= {sh[eeprom_pkg::DATA_W-2:0], sda_in};    // sample at end of high0
        else if (load)
            sh <= load_byte;
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state  <= eeprom_pkg::IDLE;
            phase  <= eeprom_pkg::PH_LOW0;
            bitcnt <= '0;
            scl_oe <= 1'b0;
            sda_oe <= 1'b0;
            busy_q <= 1'b0;
            done_q <= 1'b0;
            nack_q <= 1'b0;
        end
        else
        begin
            done_q <= 1'b0;
            case (state)
                eeprom_pkg::IDLE:
                begin
                    busy_q <= bus.start;
                    phase  <= eeprom_pkg::PH_LOW0;
                    bitcnt <= '0;
                    if (bus.start)
                    begin
                        state  <= eeprom_pkg::START;
                        nack_q <= 1'b0;
                    end
                end
                eeprom_pkg::DONE:
                begin
                    done_q <= 1'b1;
                    state  <= eeprom_pkg::IDLE;
                end
                default:
                    if (tick)
                    begin
                        phase <= eeprom_pkg::bit_phase_e'(phase + 2'd1);
                        case (phase)
                            eeprom_pkg::PH_LOW0:
                                scl_oe <= 1'b0;
                            eeprom_pkg::PH_HIGH0:
                            begin
                                if (state == eeprom_pkg::START || state == eeprom_pkg::RESTART)
                                    sda_oe <= 1'b1;       // start condition
                                else if (state == eeprom_pkg::STOP)
                                    sda_oe <= 1'b0;       // stop condition
                                else if (ack_bit && state != eeprom_pkg::DATA_RD)
                                    nack_q <= nack_q | sda_in;
                            end
                            eeprom_pkg::PH_HIGH1:
                                scl_oe <= (state != eeprom_pkg::STOP);   // bus idles high
                            default:
                            begin
                                bitcnt <= '0;
                                if (load)
                                    sda_oe <= !load_byte[eeprom_pkg::DATA_W-1];
                                case (state)
                                    eeprom_pkg::START:   state <= eeprom_pkg::CTRL_W;
                                    eeprom_pkg::RESTART: state <= eeprom_pkg::CTRL_R;
                                    eeprom_pkg::STOP:    state <= eeprom_pkg::DONE;
                                    default:
                                        if (!ack_bit)
                                        begin
                                            bitcnt <= bitcnt + 1'b1;
                                            // ack slot and read bits release SDA
                                            sda_oe <= (state != eeprom_pkg::DATA_RD) &&
                                                      (bitcnt != ACK_SLOT - 4'd1) &&
                                                      !sh[eeprom_pkg::DATA_W-1];
                                        end
                                        else if (state == eeprom_pkg::CTRL_W)
                                            state <= eeprom_pkg::ADDR;
                                        else if (state == eeprom_pkg::ADDR)
                                        begin
                                            if (op_q == eeprom_pkg::OP_READ)
                                            begin
                                                state  <= eeprom_pkg::RESTART;
                                                sda_oe <= 1'b0;
                                            end
                                            else
                                                state <= eeprom_pkg::DATA_WR;
                                        end
                                        else if (state == eeprom_pkg::CTRL_R)
                                        begin
                                            state  <= eeprom_pkg::DATA_RD;
                                            sda_oe <= 1'b0;
                                        end
                                        else
                                        begin
                                            state  <= eeprom_pkg::STOP;   // after data byte
                                            sda_oe <= 1'b1;
                                        end
                                endcase
                            end
                        endcase
                    end
            endcase
        end
    end

    assert property (@(posedge CLK) disable iff (RESET)
        ($changed(sda_oe) && !scl_oe && !$past(scl_oe)) |->
            state inside {eeprom_pkg::START, eeprom_pkg::RESTART, eeprom_pkg::STOP})
        else $error("SDA moved while SCL high outside start or stop");

    assert property (@(posedge CLK) disable iff (RESET)
        done_q |=> !done_q && !busy_q)
        else $error("done longer than one cycle or busy held after done");

endmodule

`default_nettype wire

// ==== hdl/eeprom_dispatch.sv ====
`timescale 1ns/1ps
`default_nettype none

module eeprom_dispatch #(
    parameter int NCHAN = 4
) (
    input  logic                                           CLK,
    input  logic                                           RESET,
    input  logic                                           WR,
    input  logic                                           RD,
    input  logic [$clog2(NCHAN)+eeprom_pkg::ADDR_W-1:0]    ADDR,
    input  logic [eeprom_pkg::DATA_W-1:0]                  WDATA,
    output logic                                           BUSY,
    eeprom_chan_if.dispatch                                ch [NCHAN]
);

    localparam int CHAN_W = $clog2(NCHAN);

    logic                            req_valid;
    eeprom_pkg::op_e                 req_op;
    logic [CHAN_W-1:0]               req_chan;
    logic [eeprom_pkg::ADDR_W-1:0]   req_addr;
    logic [eeprom_pkg::DATA_W-1:0]   req_wdata;
    logic                            capture;
    logic [NCHAN-1:0]                busy_v;
    logic [NCHAN-1:0]                start_v;
    eeprom_pkg::op_e                 op_q [NCHAN];

    assign capture = !req_valid && (WR || RD);   // strobes while busy are dropped
    assign BUSY = req_valid;

    always_ff @(posedge CLK)
    begin
        if (RESET)
            req_valid <= 1'b0;
        else if (capture)
            req_valid <= 1'b1;
        else if (|start_v)
            req_valid <= 1'b0;
    end

    always_ff @(posedge CLK)
    begin
        if (capture)
        begin
            req_op    <= WR ? eeprom_pkg::OP_WRITE : eeprom_pkg::OP_READ;
            req_chan  <= ADDR[CHAN_W+eeprom_pkg::ADDR_W-1:eeprom_pkg::ADDR_W];
            req_addr  <= ADDR[eeprom_pkg::ADDR_W-1:0];
            req_wdata <= WDATA;
        end
    end

    for (genvar i = 0; i < NCHAN; i++)
    begin : g_ch
        assign busy_v[i]  = ch[i].busy;
        assign start_v[i] = req_valid && (req_chan == CHAN_W'(i)) && !busy_v[i];

        assign ch[i].start = start_v[i];
        assign ch[i].op    = start_v[i] ? req_op : op_q[i];   // held until the next start
        assign ch[i].addr  = req_addr;
        assign ch[i].wdata = req_wdata;

        always_ff @(posedge CLK)
        begin
            if (start_v[i])
                op_q[i] <= req_op;
        end

        // the channel must take the request and hold off further starts
        assert property (@(posedge CLK) disable iff (RESET)
            start_v[i] |=> busy_v[i] && !start_v[i])
            else $error("channel %0d did not go busy after start", i);
    end

endmodule

`default_nettype wire

// ==== hdl/eeprom_chan_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface eeprom_chan_if;

    logic                            start;    // one cycle, only while busy is low
    eeprom_pkg::op_e                 op;
    logic [eeprom_pkg::ADDR_W-1:0]   addr;
    logic [eeprom_pkg::DATA_W-1:0]   wdata;
    logic                            busy;
    logic                            done;     // one cycle
    logic [eeprom_pkg::DATA_W-1:0]   rdata;
    logic                            nack;     // valid with done

    modport dispatch (output start, op, addr, wdata, input busy);

    modport chan (input start, op, addr, wdata, output busy, done, rdata, nack);

    modport collect (input done, rdata, nack, op);

endinterface

`default_nettype wire

// ==== hdl/eeprom_pkg.sv ====
`default_nettype none

package eeprom_pkg;

    localparam int ADDR_W = 11;            // word address inside one 2 KB device
    localparam int DATA_W = 8;
    localparam logic [3:0] DEV_TYPE = 4'b1010;

    typedef enum logic
    {
        OP_WRITE,
        OP_READ
    } op_e;

    // data states carry a direction suffix, DATA_W is already the width
    typedef enum logic [3:0]
    {
        IDLE,
        START,
        CTRL_W,
        ADDR,
        DATA_WR,
        RESTART,
        CTRL_R,
        DATA_RD,
        STOP,
        DONE
    } chan_state_e;

    // quarters of one SCL bit slot
    typedef enum logic [1:0]
    {
        PH_LOW0,
        PH_HIGH0,
        PH_HIGH1,
        PH_LOW1
    } bit_phase_e;

endpackage

`default_nettype wire
